/* Bender.yml */
package:
  name: mipsCore

sources:
  - include_dirs: [src]
    files:
      - src/mipsPkg.sv
      - src/instDecode.sv
      - src/regFile.sv
      - src/aluExecute.sv
      - src/pcNext.sv
      - src/resultStage.sv
      - src/mipsCore.sv
  - target: test
    include_dirs: [src]
    files: [bench/mipsCore_sva.sv, bench/mipsCore_tb.sv]

/* bench/mipsCore_sva.sv */
`include "mipsCore_defines.svh"

module mipsCore_sva (
  input logic             clk, rst, memCen, memWen,
  input logic [`XLEN-1:0] instAddr
);
  timeunit 1ns;
  timeprecision 1ps;

  // failed assertions so far
  int failCount = 0;

  // a write is always a selected access
  writeHasCen: assert property (@(posedge clk) disable iff (!rst) !memWen |-> !memCen)
    else begin
      failCount++;
      $error("memWen low without memCen");
    end
  // word fetch only
  pcAligned: assert property (@(posedge clk) instAddr[1:0] == 2'b00)
    else begin
      failCount++;
      $error("instAddr %h is not word aligned", instAddr);
    end
  // pc held at zero through reset
  pcZeroInReset: assert property (@(posedge clk) !rst |-> instAddr == '0)
    else begin
      failCount++;
      $error("instAddr %h while reset is low", instAddr);
    end
endmodule

bind mipsCore mipsCore_sva svaInst (
  .clk(clk), .rst(rst), .memCen(memCen), .memWen(memWen), .instAddr(instAddr)
);

/* bench/mipsCore_tb.sv */
`include "mipsCore_defines.svh"

module mipsCore_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int maxSteps = 64;
  logic clk, rst, memCen, memWen;
  logic [`XLEN-1:0] inst, memRdata, instAddr, rfWdata, memWdata;
  logic [`DMEM_AW-1:0] memAddr;
  // five words per step in file column order
  logic [31:0] stim [0:5*maxSteps-1];
  logic [`XLEN-1:0] imem [0:63];
  logic [`XLEN-1:0] dmem [0:(1<<`DMEM_AW)-1];
  int errors = 0, checks = 0, nSteps = 0;

  mipsCore dut_i (.clk(clk), .rst(rst), .inst(inst), .memRdata(memRdata),
    .instAddr(instAddr), .rfWdata(rfWdata), .memCen(memCen), .memWen(memWen),
    .memAddr(memAddr), .memWdata(memWdata));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // fetch reads as a no-op while reset is held
  assign inst     = rst ? imem[instAddr[7:2]] : '0;
  assign memRdata = dmem[memAddr];
  // store lands on the rising edge
  always @(posedge clk)
    if (!memCen && !memWen) dmem[memAddr] <= memWdata;

  task automatic compareWord(input string what, input logic [31:0] got,
                             input logic [31:0] exp, input int step, inout bit ok);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] %0t ns: step %0d %s is %h, expected %h", $time, step, what, got, exp);
      errors++;
      ok = 1'b0;
    end
  endtask

  // ======================================================================
  // program load, reset, then one check per executed instruction
  initial begin
    int i;
    int waitCycles = 0;
    bit ok;
    logic [31:0] expAddr;
    rst = 1'b0;
    for (i = 0; i < 5*maxSteps; i++) stim[i] = '1;
    // odd multiplier keeps every fill word distinct
    for (i = 0; i < (1<<`DMEM_AW); i++) dmem[i] <= i * 32'h1111_1111;
    $readmemh("bench/program_input.txt", stim);
    // each word goes to the address it runs from
    expAddr = '0;
    while (nSteps < maxSteps && stim[5*nSteps] !== '1) begin
      imem[expAddr[7:2]] = stim[5*nSteps];
      expAddr = stim[5*nSteps+1];
      nSteps++;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    for (i = 0; i < nSteps; i++) begin
      if (i > 0) @(negedge clk);
      // reset release shares this edge with step 0
      #1;
      ok = 1'b1;
      compareWord("instAddr", instAddr, (i == 0) ? 32'd0 : stim[5*i-4], i, ok);
      if (stim[5*i+3][0]) compareWord("rfWdata", rfWdata, stim[5*i+2], i, ok);
      compareWord("strobes", {30'd0, memCen, memWen}, stim[5*i+4], i, ok);
      $display("step %0d at %h: %s", i, instAddr, ok ? "ok" : "mismatch");
    end
    // last step has to reach its own target
    do begin
      @(negedge clk);
      waitCycles++;
    end while (instAddr !== expAddr && waitCycles < 16);
    if (instAddr !== expAddr) begin
      $display("timeout: instAddr never reached the final address %h", expAddr);
      errors++;
    end
    errors += dut_i.svaInst.failCount;
    $display("%0d steps, %0d checks, %0d errors", nSteps, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* bench/program_input.txt */
// inst word, next address, write-back value, write-back valid, {memCen, memWen}
8c010004 00000004 11111111 1 1
8c02000c 00000008 33333333 1 1
00221820 0000000c 44444444 1 3
00412022 00000010 22222222 1 3
00442824 00000014 22222222 1 3
00233025 00000018 55555555 1 3
0022382a 0000001c 00000001 1 3
0022403f 00000020 00000000 1 3
00220020 00000024 44444444 1 3
00004825 00000028 00000000 1 3
ac030028 0000002c 00000000 0 0
8c0a0028 00000030 44444444 1 1
10220008 00000034 00000000 0 3
106a0002 00000040 00000000 0 3
08000014 00000050 00000000 0 3
0c00001c 00000070 00000054 1 3
03e00008 00000054 00000000 0 3
08000015 00000054 00000000 0 3

/* mipsCore.f */
+incdir+src
src/mipsPkg.sv
src/instDecode.sv
src/regFile.sv
src/aluExecute.sv
src/pcNext.sv
src/resultStage.sv
src/mipsCore.sv
bench/mipsCore_sva.sv
bench/mipsCore_tb.sv

/* src/aluExecute.sv */
`include "mipsCore_defines.svh"

module aluExecute (
  input  mipsPkg::instWord_u inst,
  input  logic [`XLEN-1:0]   rdData1,
  input  logic [`XLEN-1:0]   rdData2,
  input  logic               aluSrc,
  input  logic [3:0]         aluCtrl,
  output logic [`XLEN-1:0]   aluResult,
  output logic               aluZero
);

  logic [`XLEN-1:0] immExt;
  logic [`XLEN-1:0] opB;

  // sign extend the 16 bit immediate
  assign immExt = {{(`XLEN-16){inst.iFormat.imm[15]}}, inst.iFormat.imm};

  // immediate for lw/sw, register otherwise
  assign opB = aluSrc ? immExt : rdData2;

  // ======================================================================
  // alu
  always_comb begin
    case (aluCtrl)
      `ALU_ADD: aluResult = rdData1 + opB;
      `ALU_SUB: aluResult = rdData1 - opB;
      `ALU_AND: aluResult = rdData1 & opB;
      `ALU_OR:  aluResult = rdData1 | opB;
      // unsigned compare
      `ALU_SLT: aluResult = {{(`XLEN-1){1'b0}}, (rdData1 < opB)};
      default:  aluResult = '0;
    endcase
  end

  // zero flag only meaningful for subtract (beq)
  assign aluZero = (aluCtrl == `ALU_SUB) && (aluResult == '0);

endmodule

/* src/instDecode.sv */
`include "mipsCore_defines.svh"

module instDecode (
  input  mipsPkg::instWord_u inst,
  output logic               regDst,
  output logic               aluSrc,
  output logic               memToReg,
  output logic               regWrite,
  output logic               memWrite,
  output logic               memAccess,
  output logic               branch,
  output logic               jump,
  output logic               jal,
  output logic               jr,
  output logic [3:0]         aluCtrl
);

  logic [5:0] opcode;
  logic [5:0] funct;
  logic       isRtype;
  logic       isLw;
  logic       isSw;
  logic       isBeq;
  logic       isJ;
  logic       isJal;

  // opcode from the I view, funct from the R view
  assign opcode = inst.iFormat.opcode;
  assign funct  = inst.rFormat.funct;

  assign isRtype = (opcode == `OP_RTYPE);
  assign isLw    = (opcode == `OP_LW);
  assign isSw    = (opcode == `OP_SW);
  assign isBeq   = (opcode == `OP_BEQ);
  assign isJ     = (opcode == `OP_J);
  assign isJal   = (opcode == `OP_JAL);

  // ======================================================================
  // datapath controls
  assign regDst    = isRtype;
  assign aluSrc    = isLw | isSw;
  assign memToReg  = isLw;
  assign memWrite  = isSw;
  assign memAccess = isLw | isSw;
  assign branch    = isBeq;
  assign jump      = isJ | isJal;
  assign jal       = isJal;
  assign jr        = isRtype & (funct == `FN_JR);

  // only R-format, lw and jal write back; jr is excluded
  assign regWrite  = (isRtype & ~jr) | isLw | isJal;

  // ======================================================================
  // alu control
  always_comb begin
    aluCtrl = `ALU_NOP;
    if (isLw || isSw) begin
      // address forming
      aluCtrl = `ALU_ADD;
    end else if (isBeq) begin
      // compare by subtract
      aluCtrl = `ALU_SUB;
    end else if (isRtype) begin
      case (funct)
        `FN_ADD: aluCtrl = `ALU_ADD;
        `FN_SUB: aluCtrl = `ALU_SUB;
        `FN_AND: aluCtrl = `ALU_AND;
        `FN_OR:  aluCtrl = `ALU_OR;
        `FN_SLT: aluCtrl = `ALU_SLT;
        // jr and unknown codes
        default: aluCtrl = `ALU_NOP;
      endcase
    end
  end

endmodule

/* src/mipsCore.sv */
`include "mipsCore_defines.svh"

module mipsCore (
  input  logic                clk,
  input  logic                rst,
  input  logic [`XLEN-1:0]    inst,
  input  logic [`XLEN-1:0]    memRdata,
  output logic [`XLEN-1:0]    instAddr,
  output logic [`XLEN-1:0]    rfWdata,
  output logic                memCen,
  output logic                memWen,
  output logic [`DMEM_AW-1:0] memAddr,
  output logic [`XLEN-1:0]    memWdata
);

  mipsPkg::instWord_u instW;

  // decode controls
  logic regDst, aluSrc, memToReg, regWrite, memWrite, memAccess;
  logic branch, jump, jal, jr;
  logic [3:0] aluCtrl;

  // datapath
  logic [`XLEN-1:0] rdData1;
  logic [`XLEN-1:0] rdData2;
  logic [`XLEN-1:0] aluResult;
  logic             aluZero;
  logic [`XLEN-1:0] pcPlus4;
  logic [`RAW-1:0]  wrAddr;

  assign instW    = inst;
  assign memWdata = rdData2;

  // ======================================================================
  // decode
  instDecode decodeInst (
    .inst(instW), .regDst(regDst), .aluSrc(aluSrc), .memToReg(memToReg),
    .regWrite(regWrite), .memWrite(memWrite), .memAccess(memAccess),
    .branch(branch), .jump(jump), .jal(jal), .jr(jr), .aluCtrl(aluCtrl)
  );

  // ======================================================================
  // execute
  regFile regFileInst (
    .clk(clk), .rst(rst), .rdAddr1(instW.rFormat.rs), .rdAddr2(instW.rFormat.rt),
    .wrEn(regWrite), .wrAddr(wrAddr), .wrData(rfWdata),
    .rdData1(rdData1), .rdData2(rdData2)
  );

  aluExecute aluInst (
    .inst(instW), .rdData1(rdData1), .rdData2(rdData2), .aluSrc(aluSrc),
    .aluCtrl(aluCtrl), .aluResult(aluResult), .aluZero(aluZero)
  );

  pcNext pcInst (
    .clk(clk), .rst(rst), .inst(instW), .branch(branch), .jump(jump), .jr(jr),
    .aluZero(aluZero), .rdData1(rdData1), .pc(instAddr), .pcPlus4(pcPlus4)
  );

  // ======================================================================
  // result, also the observed write-back value
  resultStage resultInst (
    .inst(instW), .regDst(regDst), .memToReg(memToReg), .jal(jal),
    .memAccess(memAccess), .memWrite(memWrite), .aluResult(aluResult),
    .memRdata(memRdata), .pcPlus4(pcPlus4), .wrAddr(wrAddr), .wrData(rfWdata),
    .memCen(memCen), .memWen(memWen), .memAddr(memAddr)
  );

endmodule

/* src/mipsCore_defines.svh */
`ifndef MIPSCORE_DEFINES_SVH
`define MIPSCORE_DEFINES_SVH

// widths
`define XLEN     32
`define DMEM_AW  7
`define RAW      5
`define LINK_REG 5'd31

// ======================================================================
// opcodes
`define OP_RTYPE 6'b000000
`define OP_LW    6'b100011
`define OP_SW    6'b101011
`define OP_BEQ   6'b000100
`define OP_J     6'b000010
`define OP_JAL   6'b000011

// function codes, R-format only
`define FN_ADD   6'b100000
`define FN_SUB   6'b100010
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_SLT   6'b101010
`define FN_JR    6'b001000

// alu control codes
`define ALU_ADD  4'b0010
`define ALU_SUB  4'b0110
`define ALU_AND  4'b0000
`define ALU_OR   4'b0001
`define ALU_SLT  4'b0111
`define ALU_NOP  4'b1111

`endif

/* src/mipsPkg.sv */
`include "mipsCore_defines.svh"

package mipsPkg;

  // ======================================================================
  // instruction word views

  // register-register layout
  typedef struct packed {
    logic [5:0]      opcode;
    logic [`RAW-1:0] rs;
    logic [`RAW-1:0] rt;
    logic [`RAW-1:0] rd;
    logic [4:0]      shamt;
    logic [5:0]      funct;
  } rFormat_s;

  // immediate layout
  // low 26 bits double as the jump target field
  typedef struct packed {
    logic [5:0]      opcode;
    logic [`RAW-1:0] rs;
    logic [`RAW-1:0] rt;
    logic [15:0]     imm;
  } iFormat_s;

  // same 32 bits, read either way
  typedef union packed {
    rFormat_s rFormat;
    iFormat_s iFormat;
  } instWord_u;

endpackage

/* src/pcNext.sv */
`include "mipsCore_defines.svh"

module pcNext (
  input  logic               clk,
  input  logic               rst,
  input  mipsPkg::instWord_u inst,
  input  logic               branch,
  input  logic               jump,
  input  logic               jr,
  input  logic               aluZero,
  input  logic [`XLEN-1:0]   rdData1,
  output logic [`XLEN-1:0]   pc,
  output logic [`XLEN-1:0]   pcPlus4
);

  logic [`XLEN-1:0] branchTarget;
  logic [`XLEN-1:0] jumpTarget;
  logic [`XLEN-1:0] nextPc;
  logic [`XLEN-1:0] immSl2;

  assign pcPlus4 = pc + `XLEN'd4;

  // sign extended offset, word aligned
  assign immSl2 = {{(`XLEN-18){inst.iFormat.imm[15]}}, inst.iFormat.imm, 2'b00};
  assign branchTarget = pcPlus4 + immSl2;

  // region bits from pc+4, 26 bit target below
  assign jumpTarget = {pcPlus4[31:28], inst.iFormat.rs, inst.iFormat.rt,
                       inst.iFormat.imm, 2'b00};

  // ======================================================================
  // next pc, jump first, then taken beq, then jr
  always_comb begin
    if (jump) begin
      nextPc = jumpTarget;
    end else if (branch && aluZero) begin
      nextPc = branchTarget;
    end else if (jr) begin
      nextPc = rdData1;
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

/* src/regFile.sv */
`include "mipsCore_defines.svh"

module regFile (
  input  logic              clk,
  input  logic              rst,
  input  logic [`RAW-1:0]   rdAddr1,
  input  logic [`RAW-1:0]   rdAddr2,
  input  logic              wrEn,
  input  logic [`RAW-1:0]   wrAddr,
  input  logic [`XLEN-1:0]  wrData,
  output logic [`XLEN-1:0]  rdData1,
  output logic [`XLEN-1:0]  rdData2
);

  // r0 has no storage
  logic [`XLEN-1:0] regs [1:31];

  // ======================================================================
  // write port
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin
      // writes to r0 dropped here
      regs[wrAddr] <= wrData;
    end
  end

  // ======================================================================
  // read ports, combinational
  // new data shows up the cycle after the write edge
  assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
  assign rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];

endmodule

/* src/resultStage.sv */
`include "mipsCore_defines.svh"

module resultStage (
  input  mipsPkg::instWord_u  inst,
  input  logic                regDst,
  input  logic                memToReg,
  input  logic                jal,
  input  logic                memAccess,
  input  logic                memWrite,
  input  logic [`XLEN-1:0]    aluResult,
  input  logic [`XLEN-1:0]    memRdata,
  input  logic [`XLEN-1:0]    pcPlus4,
  output logic [`RAW-1:0]     wrAddr,
  output logic [`XLEN-1:0]    wrData,
  output logic                memCen,
  output logic                memWen,
  output logic [`DMEM_AW-1:0] memAddr
);

  // ======================================================================
  // write-back destination
  // jal links into r31
  assign wrAddr = jal    ? `LINK_REG :
                  regDst ? inst.rFormat.rd : inst.rFormat.rt;

  // write-back value
  assign wrData = jal      ? pcPlus4  :
                  memToReg ? memRdata : aluResult;

  // ======================================================================
  // data memory side, active low strobes
  assign memCen = ~memAccess;
  assign memWen = ~memWrite;

  // byte address to word address
  assign memAddr = aluResult[`DMEM_AW+1:2];

endmodule
